// ==== include/sim_macros.svh ====
`ifndef SIM_MACROS_SVH
`define SIM_MACROS_SVH

// memory map
`define MEM_BASE       64'h0000_0000_8000_0000
`define RAM_ADDR_BITS  10

// special instruction encodings
`define TRAP_OPCODE    7'h6b
`define SKIP_INST      32'h0000_007b

// monitor register offsets
`define REG_CTRL       8'h00
`define REG_STATUS     8'h04
`define REG_CYCLE_LO   8'h08
`define REG_CYCLE_HI   8'h0C
`define REG_INSTR_LO   8'h10
`define REG_INSTR_HI   8'h14
`define REG_TPC_LO     8'h18
`define REG_TPC_HI     8'h1C

`endif

// ==== src/sim_pkg.sv ====
package sim_pkg;

  // r-type field view of an instruction word.
  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } inst_r_t;

  // same 32 bits seen as a raw word or as decoded fields.
  typedef union packed {
    logic [31:0] raw;
    inst_r_t     r;
  } inst_u;

  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_SLVERR = 2'b10
  } axi_resp_e;

endpackage

// ==== src/stats_if.sv ====
`timescale 1ns/1ps

interface stats_if;
  logic [63:0] cycle_cnt;
  logic [63:0] instr_cnt;
  logic        trapped;
  logic [7:0]  trap_code;
  logic [63:0] trap_pc;
  logic        count_en;    // level.
  logic        count_clear; // one-cycle pulse.

  modport tracker (
    output cycle_cnt, instr_cnt, trapped, trap_code, trap_pc,
    input  count_en, count_clear
  );

  modport regs (
    input  cycle_cnt, instr_cnt, trapped, trap_code, trap_pc,
    output count_en, count_clear
  );
endinterface

// ==== src/mem_bridge.sv ====
`timescale 1ns/1ps
`include "sim_macros.svh"

module mem_bridge (
  input  logic        clock,
  input  logic        reset,

  input  logic        fetch_valid_i,
  input  logic [63:0] fetch_addr_i,
  output logic        fetch_rsp_valid_o,
  output logic [31:0] fetch_rsp_data_o,

  input  logic        data_valid_i,
  input  logic [63:0] data_addr_i,
  input  logic        data_wen_i,
  input  logic [63:0] data_wdata_i,
  input  logic [7:0]  data_wstrb_i,
  output logic        data_rsp_valid_o,
  output logic [63:0] data_rsp_data_o
);

  localparam int RAM_WORDS = 1 << `RAM_ADDR_BITS;

  logic [63:0] ram [0:RAM_WORDS-1];

  logic [63:0]               fetch_off;
  logic [63:0]               data_off;
  logic [`RAM_ADDR_BITS-1:0] fetch_idx;
  logic [`RAM_ADDR_BITS-1:0] data_idx;
  logic [63:0]               fetch_word;
  logic                      data_rd;
  logic                      data_wr;

  // ********************
  // address decode
  // ********************
  assign fetch_off = fetch_addr_i - `MEM_BASE;
  assign data_off  = data_addr_i - `MEM_BASE;
  assign fetch_idx = fetch_off[`RAM_ADDR_BITS+2:3]; // 64-bit word index.
  assign data_idx  = data_off[`RAM_ADDR_BITS+2:3];

  assign fetch_word = ram[fetch_idx];
  assign data_rd    = data_valid_i & ~data_wen_i;
  assign data_wr    = data_valid_i & data_wen_i;

  // ********************
  // response path
  // ********************
  always_ff @(posedge clock) begin
    if (reset) begin
      fetch_rsp_valid_o <= 1'b0;
      data_rsp_valid_o  <= 1'b0;
    end else begin
      fetch_rsp_valid_o <= fetch_valid_i;
      data_rsp_valid_o  <= data_rd;  // writes get no response.
    end
  end

  always_ff @(posedge clock) begin
    if (fetch_valid_i) begin
      // bit 2 picks the upper or lower instruction.
      fetch_rsp_data_o <= fetch_off[2] ? fetch_word[63:32] : fetch_word[31:0];
    end
    if (data_rd) begin
      data_rsp_data_o <= ram[data_idx];
    end
  end

  // ********************
  // byte-strobed write
  // ********************
  always_ff @(posedge clock) begin
    if (data_wr) begin
      for (int b = 0; b < 8; b++) begin
        if (data_wstrb_i[b]) begin
          ram[data_idx][8*b +: 8] <= data_wdata_i[8*b +: 8];
        end
      end
    end
  end

endmodule

// ==== src/commit_tracker.sv ====
`timescale 1ns/1ps
`include "sim_macros.svh"

module commit_tracker (
  input  logic          clock,
  input  logic          reset,

  input  logic          wb_valid_i,
  input  logic [63:0]   wb_pc_i,
  input  sim_pkg::inst_u wb_inst_i,
  input  logic          wb_wen_i,
  input  logic [4:0]    wb_rd_i,
  input  logic [63:0]   wb_wdata_i,

  output logic          cmt_valid_o,
  output logic [63:0]   cmt_pc_o,
  output logic [31:0]   cmt_inst_o,
  output logic          cmt_wen_o,
  output logic [7:0]    cmt_wdest_o,
  output logic [63:0]   cmt_wdata_o,
  output logic          cmt_skip_o,
  output logic          trap_o,

  stats_if.tracker      stats
);

  logic        trapped;
  logic [7:0]  trap_code;
  logic [63:0] trap_pc;
  logic [63:0] cycle_cnt;
  logic [63:0] instr_cnt;
  logic        is_trap;

  assign is_trap = wb_valid_i && (wb_inst_i.r.opcode == `TRAP_OPCODE);

  // ********************
  // commit register
  // ********************
  always_ff @(posedge clock) begin
    if (reset) begin
      cmt_valid_o <= 1'b0;
      cmt_wen_o   <= 1'b0;
      cmt_skip_o  <= 1'b0;
      trapped     <= 1'b0;
      trap_code   <= 8'h00;
      trap_pc     <= 64'h0;
    end else if (trapped) begin
      cmt_valid_o <= 1'b0; // frozen; payload keeps the trap commit.
    end else begin
      cmt_valid_o <= wb_valid_i;
      cmt_pc_o    <= wb_pc_i;
      cmt_inst_o  <= wb_inst_i.raw;
      cmt_wen_o   <= wb_valid_i & wb_wen_i;
      cmt_wdest_o <= {3'b000, wb_rd_i};
      cmt_wdata_o <= wb_wdata_i;
      cmt_skip_o  <= (wb_inst_i.raw == `SKIP_INST);
      if (is_trap) begin
        trapped   <= 1'b1;
        trap_code <= wb_wdata_i[7:0]; // exit code from a0 writeback.
        trap_pc   <= wb_pc_i;
      end
    end
  end

  // ********************
  // counters
  // ********************
  always_ff @(posedge clock) begin
    if (reset || stats.count_clear) begin
      cycle_cnt <= 64'h0;
      instr_cnt <= 64'h0;
    end else if (stats.count_en && !trapped) begin
      cycle_cnt <= cycle_cnt + 64'd1;
      instr_cnt <= instr_cnt + {63'h0, wb_valid_i};
    end
  end

  assign trap_o          = trapped;
  assign stats.trapped   = trapped;
  assign stats.trap_code = trap_code;
  assign stats.trap_pc   = trap_pc;
  assign stats.cycle_cnt = cycle_cnt;
  assign stats.instr_cnt = instr_cnt;

endmodule

// ==== src/monitor_regs.sv ====
`timescale 1ns/1ps
`include "sim_macros.svh"

module monitor_regs (
  input  logic                clock,
  input  logic                reset,

  input  logic                s_awvalid_i,
  output logic                s_awready_o,
  input  logic [7:0]          s_awaddr_i,
  input  logic                s_wvalid_i,
  output logic                s_wready_o,
  input  logic [31:0]         s_wdata_i,
  input  logic [3:0]          s_wstrb_i,
  output logic                s_bvalid_o,
  input  logic                s_bready_i,
  output sim_pkg::axi_resp_e  s_bresp_o,

  input  logic                s_arvalid_i,
  output logic                s_arready_o,
  input  logic [7:0]          s_araddr_i,
  output logic                s_rvalid_o,
  input  logic                s_rready_i,
  output logic [31:0]         s_rdata_o,
  output sim_pkg::axi_resp_e  s_rresp_o,

  stats_if.regs               stats
);

  logic        wr_fire;
  logic        rd_fire;
  logic        count_en;
  logic        count_clear;
  logic [31:0] rd_word;

  // ********************
  // handshakes
  // ********************
  assign wr_fire = s_awvalid_i & s_wvalid_i & ~s_bvalid_o;
  assign rd_fire = s_arvalid_i & ~s_rvalid_o;

  assign s_awready_o = wr_fire; // aw and w accepted together.
  assign s_wready_o  = wr_fire;
  assign s_arready_o = rd_fire;
  assign s_bresp_o   = sim_pkg::RESP_OKAY;
  assign s_rresp_o   = sim_pkg::RESP_OKAY;

  always_ff @(posedge clock) begin
    if (reset) begin
      s_bvalid_o <= 1'b0;
      s_rvalid_o <= 1'b0;
    end else begin
      if (wr_fire) s_bvalid_o <= 1'b1;
      else if (s_bready_i) s_bvalid_o <= 1'b0;
      if (rd_fire) s_rvalid_o <= 1'b1;
      else if (s_rready_i) s_rvalid_o <= 1'b0;
    end
  end

  // ********************
  // control register
  // ********************
  always_ff @(posedge clock) begin
    if (reset) begin
      count_en    <= 1'b1;
      count_clear <= 1'b0;
    end else begin
      count_clear <= 1'b0;
      if (wr_fire && s_awaddr_i == `REG_CTRL && s_wstrb_i[0]) begin
        count_en    <= s_wdata_i[0];
        count_clear <= s_wdata_i[1]; // self-clearing.
      end
    end
  end

  assign stats.count_en    = count_en;
  assign stats.count_clear = count_clear;

  // ********************
  // read mux
  // ********************
  always_comb begin
    case (s_araddr_i)
      `REG_CTRL:     rd_word = {31'h0, count_en};
      `REG_STATUS:   rd_word = {16'h0, stats.trap_code, 7'h0, stats.trapped};
      `REG_CYCLE_LO: rd_word = stats.cycle_cnt[31:0];
      `REG_CYCLE_HI: rd_word = stats.cycle_cnt[63:32];
      `REG_INSTR_LO: rd_word = stats.instr_cnt[31:0];
      `REG_INSTR_HI: rd_word = stats.instr_cnt[63:32];
      `REG_TPC_LO:   rd_word = stats.trap_pc[31:0];
      `REG_TPC_HI:   rd_word = stats.trap_pc[63:32];
      default:       rd_word = 32'h0; // unmapped.
    endcase
  end

  always_ff @(posedge clock) begin
    if (rd_fire) begin
      s_rdata_o <= rd_word; // held until rready.
    end
  end

endmodule

// ==== src/sim_top.sv ====
`timescale 1ns/1ps

module sim_top (
  input  logic                clock,
  input  logic                reset,

  // fetch port
  input  logic                fetch_valid_i,
  input  logic [63:0]         fetch_addr_i,
  output logic                fetch_rsp_valid_o,
  output logic [31:0]         fetch_rsp_data_o,

  // data port
  input  logic                data_valid_i,
  input  logic [63:0]         data_addr_i,
  input  logic                data_wen_i,
  input  logic [63:0]         data_wdata_i,
  input  logic [7:0]          data_wstrb_i,
  output logic                data_rsp_valid_o,
  output logic [63:0]         data_rsp_data_o,

  // writeback port
  input  logic                wb_valid_i,
  input  logic [63:0]         wb_pc_i,
  input  logic [31:0]         wb_inst_i,
  input  logic                wb_wen_i,
  input  logic [4:0]          wb_rd_i,
  input  logic [63:0]         wb_wdata_i,

  // commit outputs
  output logic                cmt_valid_o,
  output logic [63:0]         cmt_pc_o,
  output logic [31:0]         cmt_inst_o,
  output logic                cmt_wen_o,
  output logic [7:0]          cmt_wdest_o,
  output logic [63:0]         cmt_wdata_o,
  output logic                cmt_skip_o,
  output logic                trap_o,

  // axi4-lite slave
  input  logic                s_awvalid_i,
  output logic                s_awready_o,
  input  logic [7:0]          s_awaddr_i,
  input  logic                s_wvalid_i,
  output logic                s_wready_o,
  input  logic [31:0]         s_wdata_i,
  input  logic [3:0]          s_wstrb_i,
  output logic                s_bvalid_o,
  input  logic                s_bready_i,
  output sim_pkg::axi_resp_e  s_bresp_o,
  input  logic                s_arvalid_i,
  output logic                s_arready_o,
  input  logic [7:0]          s_araddr_i,
  output logic                s_rvalid_o,
  input  logic                s_rready_i,
  output logic [31:0]         s_rdata_o,
  output sim_pkg::axi_resp_e  s_rresp_o
);

  stats_if stats0 ();

  mem_bridge mem0 (
    .clock (clock), .reset (reset),
    .fetch_valid_i (fetch_valid_i), .fetch_addr_i (fetch_addr_i),
    .fetch_rsp_valid_o (fetch_rsp_valid_o), .fetch_rsp_data_o (fetch_rsp_data_o),
    .data_valid_i (data_valid_i), .data_addr_i (data_addr_i),
    .data_wen_i (data_wen_i), .data_wdata_i (data_wdata_i), .data_wstrb_i (data_wstrb_i),
    .data_rsp_valid_o (data_rsp_valid_o), .data_rsp_data_o (data_rsp_data_o)
  );

  commit_tracker trk0 (
    .clock (clock), .reset (reset),
    .wb_valid_i (wb_valid_i), .wb_pc_i (wb_pc_i),
    .wb_inst_i (sim_pkg::inst_u'(wb_inst_i)),
    .wb_wen_i (wb_wen_i), .wb_rd_i (wb_rd_i), .wb_wdata_i (wb_wdata_i),
    .cmt_valid_o (cmt_valid_o), .cmt_pc_o (cmt_pc_o), .cmt_inst_o (cmt_inst_o),
    .cmt_wen_o (cmt_wen_o), .cmt_wdest_o (cmt_wdest_o), .cmt_wdata_o (cmt_wdata_o),
    .cmt_skip_o (cmt_skip_o), .trap_o (trap_o),
    .stats (stats0.tracker)
  );

  monitor_regs regs0 (
    .clock (clock), .reset (reset),
    .s_awvalid_i (s_awvalid_i), .s_awready_o (s_awready_o), .s_awaddr_i (s_awaddr_i),
    .s_wvalid_i (s_wvalid_i), .s_wready_o (s_wready_o),
    .s_wdata_i (s_wdata_i), .s_wstrb_i (s_wstrb_i),
    .s_bvalid_o (s_bvalid_o), .s_bready_i (s_bready_i), .s_bresp_o (s_bresp_o),
    .s_arvalid_i (s_arvalid_i), .s_arready_o (s_arready_o), .s_araddr_i (s_araddr_i),
    .s_rvalid_o (s_rvalid_o), .s_rready_i (s_rready_i),
    .s_rdata_o (s_rdata_o), .s_rresp_o (s_rresp_o),
    .stats (stats0.regs)
  );

endmodule

// ==== verif/sim_top_tb.sv ====
`timescale 1ns/1ps
`include "sim_macros.svh"

module sim_top_tb;

  localparam int CLK_PERIOD  = 100;
  localparam int TEST_CYCLES = 6000;
  localparam int RAM_WORDS   = 1 << `RAM_ADDR_BITS;

  logic clock, reset;
  logic fetch_valid_i, fetch_rsp_valid_o;
  logic [63:0] fetch_addr_i;
  logic [31:0] fetch_rsp_data_o;
  logic data_valid_i, data_wen_i, data_rsp_valid_o;
  logic [63:0] data_addr_i, data_wdata_i, data_rsp_data_o;
  logic [7:0] data_wstrb_i;
  logic wb_valid_i, wb_wen_i;
  logic [63:0] wb_pc_i, wb_wdata_i;
  logic [31:0] wb_inst_i;
  logic [4:0] wb_rd_i;
  logic cmt_valid_o, cmt_wen_o, cmt_skip_o, trap_o;
  logic [63:0] cmt_pc_o, cmt_wdata_o;
  logic [31:0] cmt_inst_o;
  logic [7:0] cmt_wdest_o;
  logic s_awvalid_i, s_awready_o, s_wvalid_i, s_wready_o, s_bvalid_o, s_bready_i;
  logic s_arvalid_i, s_arready_o, s_rvalid_o, s_rready_i;
  logic [7:0] s_awaddr_i, s_araddr_i;
  logic [31:0] s_wdata_i, s_rdata_o;
  logic [3:0] s_wstrb_i;
  sim_pkg::axi_resp_e s_bresp_o, s_rresp_o;

  logic [63:0] mem_model [int]; // word index to expected contents.
  int          cyc = 0;
  int          last_wr_cycle;
  logic [63:0] trap_pc_exp;
  logic [31:0] exp_status;

  sim_top dut0 (.*);

  initial begin
    clock = 1'b0;
    forever #(CLK_PERIOD / 2) clock = ~clock;
  end

  always @(posedge clock) cyc <= cyc + 1;

  initial begin
    #(2 * TEST_CYCLES * CLK_PERIOD);
    report_failure($sformatf("timeout, run went past %0d cycles", 2 * TEST_CYCLES));
  end

  // ********************
  // checking
  // ********************
  task automatic report_failure(input string what);
    $display("%s", what);
    $display("Verification failed");
    $fatal(1, "stopping at first error");
  endtask

  task automatic check_value(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      report_failure($sformatf("mismatch %s: got %h, expected %h", name, got, exp));
    end
  endtask

  function automatic logic [63:0] word_addr(input int idx);
    return `MEM_BASE + 64'(idx) * 64'd8;
  endfunction

  function automatic logic [63:0] merge_bytes(input logic [63:0] old, input logic [63:0] wdata,
                                              input logic [7:0] strb);
    logic [63:0] r;
    r = old;
    for (int b = 0; b < 8; b++) begin
      if (strb[b]) r[8*b +: 8] = wdata[8*b +: 8];
    end
    return r;
  endfunction

  // any word except one that would trap.
  function automatic logic [31:0] random_inst();
    logic [31:0] r;
    r = $urandom;
    if (r[6:0] == `TRAP_OPCODE) r[0] = ~r[0];
    return r;
  endfunction

  // ********************
  // axi drivers
  // ********************
  task automatic axi_write(input logic [7:0] addr, input logic [31:0] data,
                           input logic [3:0] strb, input int hold);
    int waited;
    waited = 0;
    @(negedge clock);
    s_awvalid_i = 1'b1;
    s_wvalid_i  = 1'b1;
    s_awaddr_i  = addr;
    s_wdata_i   = data;
    s_wstrb_i   = strb;
    s_bready_i  = (hold == 0);
    #(CLK_PERIOD / 4); // ready is combinational.
    check_value("s_awready_o", 64'(s_awready_o), 64'd1);
    check_value("s_wready_o", 64'(s_wready_o), 64'd1);
    do begin
      @(negedge clock);
      waited++;
      if (waited > 20) report_failure("write response never became valid");
    end while (!s_bvalid_o);
    last_wr_cycle = cyc; // one cycle after the handshake.
    check_value("s_awready_o", 64'(s_awready_o), 64'd0);
    check_value("s_wready_o", 64'(s_wready_o), 64'd0);
    s_awvalid_i = 1'b0;
    s_wvalid_i  = 1'b0;
    check_value("s_bresp_o", 64'(s_bresp_o), 64'(sim_pkg::RESP_OKAY));
    for (int i = 0; i < hold; i++) begin
      @(negedge clock);
      check_value("s_bvalid_o", 64'(s_bvalid_o), 64'd1);
    end
    s_bready_i = 1'b1;
    @(negedge clock);
    s_bready_i = 1'b0;
    check_value("s_bvalid_o", 64'(s_bvalid_o), 64'd0);
  endtask

  task automatic axi_read(input logic [7:0] addr, input int hold, output logic [31:0] data);
    int waited;
    waited = 0;
    @(negedge clock);
    s_arvalid_i = 1'b1;
    s_araddr_i  = addr;
    s_rready_i  = (hold == 0);
    #(CLK_PERIOD / 4);
    check_value("s_arready_o", 64'(s_arready_o), 64'd1);
    do begin
      @(negedge clock);
      waited++;
      if (waited > 20) report_failure("read data never became valid");
    end while (!s_rvalid_o);
    check_value("s_arready_o", 64'(s_arready_o), 64'd0);
    s_arvalid_i = 1'b0;
    data = s_rdata_o;
    check_value("s_rresp_o", 64'(s_rresp_o), 64'(sim_pkg::RESP_OKAY));
    for (int i = 0; i < hold; i++) begin
      @(negedge clock);
      check_value("s_rvalid_o", 64'(s_rvalid_o), 64'd1);
      check_value("s_rdata_o", 64'(s_rdata_o), 64'(data));
    end
    s_rready_i = 1'b1;
    @(negedge clock);
    s_rready_i = 1'b0;
    check_value("s_rvalid_o", 64'(s_rvalid_o), 64'd0);
  endtask

  // ********************
  // core drivers
  // ********************
  task automatic mem_write(input int idx, input logic [63:0] data, input logic [7:0] strb);
    @(negedge clock);
    data_valid_i = 1'b1;
    data_wen_i   = 1'b1;
    data_addr_i  = word_addr(idx);
    data_wdata_i = data;
    data_wstrb_i = strb;
    mem_model[idx] = merge_bytes(mem_model.exists(idx) ? mem_model[idx] : 64'h0, data, strb);
    @(negedge clock);
    data_valid_i = 1'b0;
    data_wen_i   = 1'b0;
    check_value("data_rsp_valid_o", 64'(data_rsp_valid_o), 64'd0); // no write response.
  endtask

  task automatic mem_read(input int idx);
    @(negedge clock);
    data_valid_i = 1'b1;
    data_wen_i   = 1'b0;
    data_addr_i  = word_addr(idx);
    @(negedge clock);
    data_valid_i = 1'b0;
    check_value("data_rsp_valid_o", 64'(data_rsp_valid_o), 64'd1);
    check_value("data_rsp_data_o", data_rsp_data_o, mem_model[idx]);
    @(negedge clock);
    check_value("data_rsp_valid_o", 64'(data_rsp_valid_o), 64'd0);
  endtask

  task automatic fetch(input int idx, input logic half);
    @(negedge clock);
    fetch_valid_i = 1'b1;
    fetch_addr_i  = word_addr(idx) + (half ? 64'd4 : 64'd0);
    @(negedge clock);
    fetch_valid_i = 1'b0;
    check_value("fetch_rsp_valid_o", 64'(fetch_rsp_valid_o), 64'd1);
    check_value("fetch_rsp_data_o", 64'(fetch_rsp_data_o),
                64'(half ? mem_model[idx][63:32] : mem_model[idx][31:0]));
    @(negedge clock);
    check_value("fetch_rsp_valid_o", 64'(fetch_rsp_valid_o), 64'd0);
  endtask

  task automatic drive_wb(input logic v, input logic [63:0] pc, input logic [31:0] inst,
                          input logic wen, input logic [4:0] rd, input logic [63:0] wdata);
    wb_valid_i = v;
    wb_pc_i    = pc;
    wb_inst_i  = inst;
    wb_wen_i   = wen;
    wb_rd_i    = rd;
    wb_wdata_i = wdata;
  endtask

  task automatic commit(input logic v, input logic [63:0] pc, input logic [31:0] inst,
                        input logic wen, input logic [4:0] rd, input logic [63:0] wdata);
    @(negedge clock);
    drive_wb(v, pc, inst, wen, rd, wdata);
    @(negedge clock);
    wb_valid_i = 1'b0;
    check_value("cmt_valid_o", 64'(cmt_valid_o), 64'(v));
    check_value("cmt_wen_o", 64'(cmt_wen_o), 64'(v & wen));
    if (v) begin
      check_value("cmt_pc_o", cmt_pc_o, pc);
      check_value("cmt_inst_o", 64'(cmt_inst_o), 64'(inst));
      check_value("cmt_wdest_o", 64'(cmt_wdest_o), 64'(rd));
      check_value("cmt_wdata_o", cmt_wdata_o, wdata);
      check_value("cmt_skip_o", 64'(cmt_skip_o), 64'(inst == `SKIP_INST));
    end
  endtask

  // ********************
  // tests
  // ********************
  task automatic strobe_readback();
    int idx;
    for (int i = 0; i < 16; i++) begin
      idx = int'($urandom % RAM_WORDS);
      mem_write(idx, {$urandom, $urandom}, 8'hff);
      mem_write(idx, {$urandom, $urandom}, 8'($urandom));
      mem_read(idx);
    end
    foreach (mem_model[k]) mem_read(k);
  endtask

  task automatic fetch_halves();
    int idx;
    for (int i = 0; i < 4; i++) begin
      idx = int'($urandom % RAM_WORDS);
      mem_write(idx, {$urandom, $urandom}, 8'hff);
      fetch(idx, 1'b0);
      fetch(idx, 1'b1);
    end
  endtask

  task automatic commit_passthrough();
    logic        v;
    logic [31:0] inst;
    for (int i = 0; i < 12; i++) begin
      v = ($urandom % 4) != 0;
      inst = random_inst();
      if (i == 5) begin
        v = 1'b1;
        inst = `SKIP_INST;
      end
      commit(v, {$urandom, $urandom}, inst, 1'($urandom), 5'($urandom), {$urandom, $urandom});
    end
  endtask

  task automatic counter_window();
    logic [31:0] d;
    int          m;
    int          t0;
    int          win;
    axi_read(`REG_CTRL, 0, d);
    check_value("CTRL after reset", 64'(d), 64'd1);
    axi_write(`REG_CTRL, 32'h2, 4'h1, 0); // stop and clear.
    axi_write(`REG_CTRL, 32'h1, 4'h1, 0);
    t0 = last_wr_cycle;
    m = 5 + int'($urandom % 8);
    for (int i = 0; i < m; i++) begin
      repeat (int'($urandom % 3)) @(negedge clock);
      commit(1'b1, {$urandom, $urandom}, random_inst(), 1'b1, 5'($urandom), {$urandom, $urandom});
    end
    axi_write(`REG_CTRL, 32'h0, 4'h1, 0);
    win = last_wr_cycle - t0;
    axi_read(`REG_INSTR_LO, 0, d);
    check_value("INSTR_LO", 64'(d), 64'(m));
    axi_read(`REG_INSTR_HI, 0, d);
    check_value("INSTR_HI", 64'(d), 64'd0);
    axi_read(`REG_CYCLE_LO, 0, d);
    if (int'(d) < win - 2 || int'(d) > win + 2) begin
      report_failure($sformatf("cycle count %0d is outside the window %0d plus or minus 2",
                               d, win));
    end
    axi_write(`REG_CTRL, 32'h2, 4'h1, 0);
    for (int off = `REG_CYCLE_LO; off <= `REG_INSTR_HI; off += 4) begin
      axi_read(8'(off), 0, d);
      check_value("counter after clear", 64'(d), 64'd0);
    end
  endtask

  task automatic trap_freeze();
    logic [31:0] inst;
    logic [31:0] d;
    logic [31:0] first_cycle;
    logic [31:0] first_instr;
    logic [7:0]  code;
    code = 8'($urandom);
    trap_pc_exp = {$urandom, $urandom} & ~64'h3;
    inst = random_inst();
    inst[6:0] = `TRAP_OPCODE;
    axi_write(`REG_CTRL, 32'h1, 4'h1, 0);
    commit(1'b1, trap_pc_exp, inst, 1'b1, 5'd10, {32'($urandom), 24'($urandom), code});
    check_value("trap_o", 64'(trap_o), 64'd1);
    exp_status = {16'h0, code, 7'h0, 1'b1};
    axi_read(`REG_STATUS, 0, d);
    check_value("STATUS", 64'(d), 64'(exp_status));
    axi_read(`REG_TPC_LO, 0, d);
    check_value("TPC_LO", 64'(d), 64'(trap_pc_exp[31:0]));
    axi_read(`REG_TPC_HI, 0, d);
    check_value("TPC_HI", 64'(d), 64'(trap_pc_exp[63:32]));
    axi_read(`REG_CYCLE_LO, 0, first_cycle);
    axi_read(`REG_INSTR_LO, 0, first_instr);
    for (int i = 0; i < 3; i++) begin
      @(negedge clock);
      drive_wb(1'b1, {$urandom, $urandom}, random_inst(), 1'b1, 5'($urandom), {$urandom, $urandom});
      @(negedge clock);
      wb_valid_i = 1'b0;
      check_value("cmt_valid_o", 64'(cmt_valid_o), 64'd0);
      check_value("cmt_pc_o", cmt_pc_o, trap_pc_exp); // trap commit is held.
      check_value("trap_o", 64'(trap_o), 64'd1);
    end
    axi_read(`REG_CYCLE_LO, 0, d);
    check_value("CYCLE_LO after trap", 64'(d), 64'(first_cycle));
    axi_read(`REG_INSTR_LO, 0, d);
    check_value("INSTR_LO after trap", 64'(d), 64'(first_instr));
  endtask

  task automatic axi_corner_cases();
    logic [31:0] d;
    axi_read(8'h40, 0, d);
    check_value("unmapped read", 64'(d), 64'd0);
    axi_write(`REG_STATUS, 32'hffff_ffff, 4'hf, 0);
    axi_read(`REG_STATUS, 0, d);
    check_value("STATUS after write", 64'(d), 64'(exp_status));
    axi_read(`REG_TPC_LO, 6, d); // rready held low.
    check_value("TPC_LO held", 64'(d), 64'(trap_pc_exp[31:0]));
    axi_write(8'h80, 32'h1234_5678, 4'hf, 5);
  endtask

  // ********************
  // main sequence
  // ********************
  initial begin
    void'($urandom(32'hd4ba));
    reset = 1'b1;
    drive_wb(1'b0, 64'h0, 32'h0, 1'b0, 5'h0, 64'h0);
    fetch_valid_i = 1'b0;
    fetch_addr_i  = 64'h0;
    data_valid_i  = 1'b0;
    data_wen_i    = 1'b0;
    data_addr_i   = 64'h0;
    data_wdata_i  = 64'h0;
    data_wstrb_i  = 8'h0;
    s_awvalid_i   = 1'b0;
    s_awaddr_i    = 8'h0;
    s_wvalid_i    = 1'b0;
    s_wdata_i     = 32'h0;
    s_wstrb_i     = 4'h0;
    s_bready_i    = 1'b0;
    s_arvalid_i   = 1'b0;
    s_araddr_i    = 8'h0;
    s_rready_i    = 1'b0;
    repeat (5) @(posedge clock);
    @(negedge clock);
    reset = 1'b0;
    check_value("fetch_rsp_valid_o", 64'(fetch_rsp_valid_o), 64'd0);
    check_value("data_rsp_valid_o", 64'(data_rsp_valid_o), 64'd0);
    check_value("cmt_valid_o", 64'(cmt_valid_o), 64'd0);
    check_value("trap_o", 64'(trap_o), 64'd0);
    check_value("s_bvalid_o", 64'(s_bvalid_o), 64'd0);
    check_value("s_rvalid_o", 64'(s_rvalid_o), 64'd0);
    strobe_readback();
    fetch_halves();
    commit_passthrough();
    counter_window();
    trap_freeze();
    axi_corner_cases();
    $display("Verification passed");
    $finish;
  end

endmodule

// ==== sources.f ====
+incdir+include
src/sim_pkg.sv
src/stats_if.sv
src/mem_bridge.sv
src/commit_tracker.sv
src/monitor_regs.sv
src/sim_top.sv
verif/sim_top_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f sources.f --top-module sim_top_tb -o sim_top_tb_bin

./obj_dir/sim_top_tb_bin 2>&1 | tee sim.log

if grep -q "^Verification passed$" sim.log; then
  echo "run_sim: PASS"
else
  echo "run_sim: FAIL"
  exit 1
fi
